// File: hw/bind_fsm.sv
module bind_fsm (
    input  logic                s00_axis_fw_lookup_aclk,
    input  logic                rst_n,
    input  logic                ctrl_req_valid,
    input  conn_pkg::ip_addr_t  ctrl_req_ip,
    input  conn_pkg::udp_port_t ctrl_req_port,
    input  logic                ctrl_req_bind,
    output logic                ctrl_req_ready,
    output logic                ctrl_resp_valid,
    output conn_pkg::conn_id_t  ctrl_resp_conn_id,
    output logic                ctrl_resp_full,
    conn_table_if.ctrl          tbl
);
    import conn_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ_WAIT,
        ST_BIND_CHECK,
        ST_ALLOC_SCAN,
        ST_UNBIND_CLEAR
    } state_t;

    state_t                 state;
    // One-hot countdown of the table read
    logic [RAM_LATENCY-1:0] wait_sr;
    way_idx_t               scan_way;
    logic [WAYS-1:0]        wren_q;

    // Latched command
    tag_t                   key_q;
    hash_idx_t              hash_q;
    logic                   bind_q;

    logic [WAYS-1:0]        tag_match;
    logic [WAYS-1:0]        hit_vec;
    logic [WAYS-1:0]        free_vec;
    way_idx_t               hit_way;

    // Busy also during the response pulse
    assign ctrl_req_ready = (state == ST_IDLE) && !ctrl_resp_valid;

    // ----------------------------------------
    // Table port
    // ----------------------------------------

    assign tbl.addr     = hash_q;
    assign tbl.wren     = wren_q;
    // Unbind writes the same key with valid low
    assign tbl.wr_entry = {bind_q, key_q};

    // Per-way compare on the read data
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            tag_match[w] = (tbl.rd_entry[w].tag == key_q);
            hit_vec[w]   = tag_match[w] && tbl.rd_entry[w].valid;
            free_vec[w]  = !tbl.rd_entry[w].valid;
            if (hit_vec[w]) begin
                hit_way = way_idx_t'(w);
            end
        end
    end

    always_ff @(posedge s00_axis_fw_lookup_aclk) begin
        if (ctrl_req_valid && ctrl_req_ready) begin
            key_q  <= {ctrl_req_ip, ctrl_req_port};
            hash_q <= hash_tag({ctrl_req_ip, ctrl_req_port});
            bind_q <= ctrl_req_bind;
        end
    end

    // ----------------------------------------
    // Command FSM
    // ----------------------------------------

    always_ff @(posedge s00_axis_fw_lookup_aclk) begin
        if (!rst_n) begin
            state             <= ST_IDLE;
            wait_sr           <= '0;
            scan_way          <= '0;
            wren_q            <= '0;
            ctrl_resp_valid   <= 1'b0;
            ctrl_resp_full    <= 1'b0;
            ctrl_resp_conn_id <= '0;
        end else begin
            // Strobes last one cycle
            wren_q          <= '0;
            ctrl_resp_valid <= 1'b0;
            ctrl_resp_full  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (ctrl_req_valid && ctrl_req_ready) begin
                        wait_sr  <= RAM_LATENCY'(1);
                        scan_way <= '0;
                        state    <= ST_READ_WAIT;
                    end
                end
                ST_READ_WAIT: begin
                    wait_sr <= wait_sr << 1;
                    if (wait_sr[RAM_LATENCY-1]) begin
                        state <= bind_q ? ST_BIND_CHECK : ST_UNBIND_CLEAR;
                    end
                end
                ST_BIND_CHECK: begin
                    // Key already bound, hand back its id
                    if (|hit_vec) begin
                        ctrl_resp_valid   <= 1'b1;
                        ctrl_resp_conn_id <= '{way: hit_way, hash: hash_q};
                        state             <= ST_IDLE;
                    end else begin
                        state <= ST_ALLOC_SCAN;
                    end
                end
                ST_ALLOC_SCAN: begin
                    // Lowest free way wins, one way per cycle
                    if (free_vec[scan_way]) begin
                        wren_q[scan_way]  <= 1'b1;
                        ctrl_resp_valid   <= 1'b1;
                        ctrl_resp_conn_id <= '{way: scan_way, hash: hash_q};
                        state             <= ST_IDLE;
                    end else if (scan_way == way_idx_t'(WAYS - 1)) begin
                        ctrl_resp_valid   <= 1'b1;
                        ctrl_resp_full    <= 1'b1;
                        ctrl_resp_conn_id <= '0;
                        state             <= ST_IDLE;
                    end else begin
                        scan_way <= scan_way + 1'b1;
                    end
                end
                ST_UNBIND_CLEAR: begin
                    // Every matching way goes invalid
                    wren_q            <= tag_match;
                    ctrl_resp_valid   <= 1'b1;
                    ctrl_resp_conn_id <= '0;
                    state             <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

// File: hw/conn_manager.sv
module conn_manager (
    input  logic                s00_axis_fw_lookup_aclk,
    input  logic                rst_n,

    // Forward lookup
    input  logic                fw_req_valid,
    input  conn_pkg::ip_addr_t  fw_req_ip,
    input  conn_pkg::udp_port_t fw_req_port,
    output logic                fw_resp_valid,
    output logic                fw_resp_hit,
    output conn_pkg::conn_id_t  fw_resp_conn_id,

    // Bind and unbind
    input  logic                ctrl_req_valid,
    input  conn_pkg::ip_addr_t  ctrl_req_ip,
    input  conn_pkg::udp_port_t ctrl_req_port,
    input  logic                ctrl_req_bind,
    output logic                ctrl_req_ready,
    output logic                ctrl_resp_valid,
    output conn_pkg::conn_id_t  ctrl_resp_conn_id,
    output logic                ctrl_resp_full
);
    import conn_pkg::*;

    // ----------------------------------------
    // Internal wiring
    // ----------------------------------------

    hash_idx_t fw_addr;
    entry_t    fw_entries [WAYS];

    conn_table_if tbl_if ();

    fw_lookup i_fw_lookup (
        .s00_axis_fw_lookup_aclk (s00_axis_fw_lookup_aclk),
        .rst_n                   (rst_n),
        .fw_req_valid            (fw_req_valid),
        .fw_req_ip               (fw_req_ip),
        .fw_req_port             (fw_req_port),
        .fw_addr                 (fw_addr),
        .fw_entries              (fw_entries),
        .fw_resp_valid           (fw_resp_valid),
        .fw_resp_hit             (fw_resp_hit),
        .fw_resp_conn_id         (fw_resp_conn_id)
    );

    conn_table i_conn_table (
        .s00_axis_fw_lookup_aclk (s00_axis_fw_lookup_aclk),
        .rst_n                   (rst_n),
        .fw_addr                 (fw_addr),
        .fw_entries              (fw_entries),
        .tbl                     (tbl_if.mem)
    );

    bind_fsm i_bind_fsm (
        .s00_axis_fw_lookup_aclk (s00_axis_fw_lookup_aclk),
        .rst_n                   (rst_n),
        .ctrl_req_valid          (ctrl_req_valid),
        .ctrl_req_ip             (ctrl_req_ip),
        .ctrl_req_port           (ctrl_req_port),
        .ctrl_req_bind           (ctrl_req_bind),
        .ctrl_req_ready          (ctrl_req_ready),
        .ctrl_resp_valid         (ctrl_resp_valid),
        .ctrl_resp_conn_id       (ctrl_resp_conn_id),
        .ctrl_resp_full          (ctrl_resp_full),
        .tbl                     (tbl_if.ctrl)
    );

endmodule

// File: hw/conn_pkg.sv
package conn_pkg;

    // ----------------------------------------
    // Sizes
    // ----------------------------------------

    localparam int IP_WIDTH      = 32;
    localparam int PORT_WIDTH    = 16;
    // Key is IP above port
    localparam int TAG_WIDTH     = 48;
    localparam int HASH_WIDTH    = 4;
    localparam int INDEXES       = 16;
    localparam int WAYS          = 4;
    localparam int WAYS_LOG      = 2;
    // Way index above hash index
    localparam int CONN_ID_WIDTH = 6;
    // Address to read data, in cycles
    localparam int RAM_LATENCY   = 2;

    // ----------------------------------------
    // Types
    // ----------------------------------------

    typedef logic [IP_WIDTH-1:0]   ip_addr_t;
    typedef logic [PORT_WIDTH-1:0] udp_port_t;
    typedef logic [HASH_WIDTH-1:0] hash_idx_t;
    typedef logic [WAYS_LOG-1:0]   way_idx_t;

    typedef struct packed {
        ip_addr_t  ip;
        udp_port_t port;
    } tag_t;

    typedef struct packed {
        way_idx_t  way;
        hash_idx_t hash;
    } conn_id_t;

    // One way of one set
    typedef struct packed {
        logic valid;
        tag_t tag;
    } entry_t;

    // XOR fold of the key into one set index
    function automatic hash_idx_t hash_tag(input tag_t tag);
        hash_idx_t            h;
        logic [TAG_WIDTH-1:0] bits;
        h    = '0;
        bits = tag;
        for (int i = 0; i < TAG_WIDTH / HASH_WIDTH; i++) begin
            h ^= bits[i*HASH_WIDTH +: HASH_WIDTH];
        end
        return h;
    endfunction

endpackage

// File: hw/conn_table.sv
module conn_table (
    input  logic                s00_axis_fw_lookup_aclk,
    input  logic                rst_n,
    input  conn_pkg::hash_idx_t fw_addr,
    output conn_pkg::entry_t    fw_entries [conn_pkg::WAYS],
    conn_table_if.mem           tbl
);
    import conn_pkg::*;

    // ----------------------------------------
    // One memory per way
    // ----------------------------------------

    // Addresses and write data shared by all ways
    // Only the write strobe is per way
    for (genvar w = 0; w < WAYS; w++) begin : g_way
        way_ram i_way_ram (
            .s00_axis_fw_lookup_aclk (s00_axis_fw_lookup_aclk),
            .rst_n                   (rst_n),
            .fw_addr                 (fw_addr),
            .fw_entry                (fw_entries[w]),
            .ctrl_addr               (tbl.addr),
            .ctrl_wren               (tbl.wren[w]),
            .ctrl_wr_entry           (tbl.wr_entry),
            .ctrl_entry              (tbl.rd_entry[w])
        );
    end

endmodule

// File: hw/conn_table_if.sv
interface conn_table_if;
    import conn_pkg::*;

    // Set index, held for a whole command
    hash_idx_t       addr;
    // One write strobe per way
    logic [WAYS-1:0] wren;
    entry_t          wr_entry;
    // All ways at addr, RAM_LATENCY cycles late
    entry_t          rd_entry [WAYS];

    // Command FSM side
    modport ctrl (
        output addr,
        output wren,
        output wr_entry,
        input  rd_entry
    );

    // Way memory side
    modport mem (
        input  addr,
        input  wren,
        input  wr_entry,
        output rd_entry
    );

endinterface

// File: hw/fw_lookup.sv
module fw_lookup (
    input  logic                s00_axis_fw_lookup_aclk,
    input  logic                rst_n,
    input  logic                fw_req_valid,
    input  conn_pkg::ip_addr_t  fw_req_ip,
    input  conn_pkg::udp_port_t fw_req_port,
    output conn_pkg::hash_idx_t fw_addr,
    input  conn_pkg::entry_t    fw_entries [conn_pkg::WAYS],
    output logic                fw_resp_valid,
    output logic                fw_resp_hit,
    output conn_pkg::conn_id_t  fw_resp_conn_id
);
    import conn_pkg::*;

    tag_t                 req_key;
    // Stage 0 is the input register, stage RAM_LATENCY meets the read data
    logic [RAM_LATENCY:0] valid_pipe;
    tag_t                 key_pipe  [RAM_LATENCY+1];
    hash_idx_t            hash_pipe [RAM_LATENCY+1];

    assign req_key = {fw_req_ip, fw_req_port};

    // ----------------------------------------
    // Delay lines
    // ----------------------------------------

    always_ff @(posedge s00_axis_fw_lookup_aclk) begin
        if (!rst_n) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[RAM_LATENCY-1:0], fw_req_valid};
        end
    end

    always_ff @(posedge s00_axis_fw_lookup_aclk) begin
        key_pipe[0]  <= req_key;
        hash_pipe[0] <= hash_tag(req_key);
        for (int i = 1; i <= RAM_LATENCY; i++) begin
            key_pipe[i]  <= key_pipe[i-1];
            hash_pipe[i] <= hash_pipe[i-1];
        end
    end

    // Table read starts from the registered hash
    assign fw_addr = hash_pipe[0];

    // ----------------------------------------
    // Tag compare
    // ----------------------------------------

    // At most one way holds a given key
    always_comb begin
        fw_resp_hit     = 1'b0;
        fw_resp_conn_id = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (fw_entries[w].valid && (fw_entries[w].tag == key_pipe[RAM_LATENCY])) begin
                fw_resp_hit     = 1'b1;
                fw_resp_conn_id = '{way: way_idx_t'(w), hash: hash_pipe[RAM_LATENCY]};
            end
        end
    end

    assign fw_resp_valid = valid_pipe[RAM_LATENCY];

endmodule

// File: hw/way_ram.sv
module way_ram (
    input  logic                s00_axis_fw_lookup_aclk,
    input  logic                rst_n,
    input  conn_pkg::hash_idx_t fw_addr,
    output conn_pkg::entry_t    fw_entry,
    input  conn_pkg::hash_idx_t ctrl_addr,
    input  logic                ctrl_wren,
    input  conn_pkg::entry_t    ctrl_wr_entry,
    output conn_pkg::entry_t    ctrl_entry
);
    import conn_pkg::*;

    // Per-index valid flags
    logic [INDEXES-1:0] valid_bits;
    // Key storage
    tag_t               tag_mem [INDEXES];

    // Read data delay lines
    entry_t fw_pipe   [RAM_LATENCY];
    entry_t ctrl_pipe [RAM_LATENCY];

    // ----------------------------------------
    // Write port
    // ----------------------------------------

    always_ff @(posedge s00_axis_fw_lookup_aclk) begin
        if (!rst_n) begin
            valid_bits <= '0;
        end else if (ctrl_wren) begin
            valid_bits[ctrl_addr] <= ctrl_wr_entry.valid;
        end
    end

    always_ff @(posedge s00_axis_fw_lookup_aclk) begin
        if (ctrl_wren) begin
            tag_mem[ctrl_addr] <= ctrl_wr_entry.tag;
        end
    end

    // ----------------------------------------
    // Read ports
    // ----------------------------------------

    // Old contents seen on a same-edge write
    always_ff @(posedge s00_axis_fw_lookup_aclk) begin
        fw_pipe[0]   <= '{valid: valid_bits[fw_addr], tag: tag_mem[fw_addr]};
        ctrl_pipe[0] <= '{valid: valid_bits[ctrl_addr], tag: tag_mem[ctrl_addr]};
        for (int i = 1; i < RAM_LATENCY; i++) begin
            fw_pipe[i]   <= fw_pipe[i-1];
            ctrl_pipe[i] <= ctrl_pipe[i-1];
        end
    end

    assign fw_entry   = fw_pipe[RAM_LATENCY-1];
    assign ctrl_entry = ctrl_pipe[RAM_LATENCY-1];

endmodule

// File: run.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_conn_manager --Mdir obj_dir -f vlog.f

./obj_dir/Vtb_conn_manager +verilator+error+limit+1000 | tee sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

// File: tests/conn_manager_sva.sv
module conn_manager_sva (
    input logic s00_axis_fw_lookup_aclk,
    input logic rst_n,
    input logic fw_req_valid,
    input logic fw_resp_valid,
    input logic ctrl_req_valid,
    input logic ctrl_req_ready,
    input logic ctrl_resp_valid,
    input logic ctrl_resp_full
);
    import conn_pkg::*;

    // Failed assertions, read by the testbench summary
    int unsigned fail_count = 0;

    // ----------------------------------------
    // Forward path
    // ----------------------------------------

    // One response per request, RAM_LATENCY+1 edges later
    fw_latency: assert property (@(posedge s00_axis_fw_lookup_aclk) disable iff (!rst_n)
        fw_resp_valid == $past(fw_req_valid, RAM_LATENCY + 1))
    else begin
        fail_count++;
        $error("Forward response not 3 cycles after its request");
    end

    // ----------------------------------------
    // Control path
    // ----------------------------------------

    // Pulse of one cycle, then ready again
    ctrl_pulse: assert property (@(posedge s00_axis_fw_lookup_aclk) disable iff (!rst_n)
        ctrl_resp_valid |=> !ctrl_resp_valid && ctrl_req_ready)
    else begin
        fail_count++;
        $error("Control response longer than one cycle or ready not back after it");
    end

    // Busy right after acceptance
    ctrl_accept: assert property (@(posedge s00_axis_fw_lookup_aclk) disable iff (!rst_n)
        ctrl_req_valid && ctrl_req_ready |=> !ctrl_req_ready)
    else begin
        fail_count++;
        $error("Ready still high after a command was accepted");
    end

    // Stays busy until the pulse, and busy during it
    ctrl_busy: assert property (@(posedge s00_axis_fw_lookup_aclk) disable iff (!rst_n)
        (!ctrl_req_ready && !ctrl_resp_valid) |=> !ctrl_req_ready || ctrl_resp_valid)
    else begin
        fail_count++;
        $error("Ready rose before the control response");
    end

    ctrl_resp_busy: assert property (@(posedge s00_axis_fw_lookup_aclk) disable iff (!rst_n)
        ctrl_resp_valid |-> !ctrl_req_ready)
    else begin
        fail_count++;
        $error("Ready high during the control response");
    end

    // Output levels right after reset release
    reset_values: assert property (@(posedge s00_axis_fw_lookup_aclk)
        $rose(rst_n) |-> !fw_resp_valid && !ctrl_resp_valid && !ctrl_resp_full && ctrl_req_ready)
    else begin
        fail_count++;
        $error("Wrong output values after reset");
    end

endmodule

bind conn_manager conn_manager_sva i_sva (
    .s00_axis_fw_lookup_aclk (s00_axis_fw_lookup_aclk),
    .rst_n                   (rst_n),
    .fw_req_valid            (fw_req_valid),
    .fw_resp_valid           (fw_resp_valid),
    .ctrl_req_valid          (ctrl_req_valid),
    .ctrl_req_ready          (ctrl_req_ready),
    .ctrl_resp_valid         (ctrl_resp_valid),
    .ctrl_resp_full          (ctrl_resp_full)
);

// File: tests/tb_clock.sv
module tb_clock (
    output logic s00_axis_fw_lookup_aclk,
    output logic rst_n
);

    // Period of 4 time units
    initial begin
        s00_axis_fw_lookup_aclk = 1'b0;
        forever #2 s00_axis_fw_lookup_aclk = ~s00_axis_fw_lookup_aclk;
    end

    // Reset low for five rising edges, released just after the fifth
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge s00_axis_fw_lookup_aclk);
        #1 rst_n = 1'b1;
    end

endmodule

// File: tests/tb_conn_manager.sv
module tb_conn_manager;
    import conn_pkg::*;

    // Upper bound on lookups plus commands in the run
    localparam int OPS            = 40;
    localparam int WATCHDOG_LIMIT = OPS * (RAM_LATENCY + WAYS + 6) * 4 + 200;

    logic      s00_axis_fw_lookup_aclk;
    logic      rst_n;
    logic      fw_req_valid;
    ip_addr_t  fw_req_ip;
    udp_port_t fw_req_port;
    logic      fw_resp_valid;
    logic      fw_resp_hit;
    conn_id_t  fw_resp_conn_id;
    logic      ctrl_req_valid;
    ip_addr_t  ctrl_req_ip;
    udp_port_t ctrl_req_port;
    logic      ctrl_req_bind;
    logic      ctrl_req_ready;
    logic      ctrl_resp_valid;
    conn_id_t  ctrl_resp_conn_id;
    logic      ctrl_resp_full;

    integer    seed = 32'hbd32_5cfc;
    int        errors = 0;

    // Reference table, way by set
    logic      model_valid [WAYS][INDEXES];
    tag_t      model_tag   [WAYS][INDEXES];

    // Outstanding forward lookups, oldest first
    string     exp_name [$];
    logic      exp_hit  [$];
    conn_id_t  exp_id   [$];
    string     mon_name;
    logic      mon_hit;
    conn_id_t  mon_id;

    // Keys 0 to 4 share hash ha, keys 5 and 6 share hb
    tag_t      keys [7];
    hash_idx_t ha;
    hash_idx_t hb;

    tb_clock i_clock (
        .s00_axis_fw_lookup_aclk (s00_axis_fw_lookup_aclk),
        .rst_n                   (rst_n)
    );

    conn_manager i_dut (.*);

    // ----------------------------------------
    // Keys and reference model
    // ----------------------------------------

    task automatic make_key(input hash_idx_t h, output tag_t k);
        logic [31:0] r;
        r      = $random(seed);
        k.ip   = r;
        r      = $random(seed);
        k.port = r[15:0];
        // Low nibble adjusted so the key folds onto set h
        k.port[3:0] = k.port[3:0] ^ hash_tag(k) ^ h;
    endtask

    task automatic model_lookup(input hash_idx_t h, input tag_t k,
                                output logic hit, output conn_id_t id);
        hit = 1'b0;
        id  = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (model_valid[w][h] && model_tag[w][h] == k) begin
                hit = 1'b1;
                id  = '{way: way_idx_t'(w), hash: h};
            end
        end
    endtask

    // Existing id first, else lowest free way, else full
    task automatic model_bind(input hash_idx_t h, input tag_t k,
                              output logic full, output conn_id_t id);
        logic found;
        model_lookup(h, k, found, id);
        for (int w = 0; w < WAYS; w++) begin
            if (!found && !model_valid[w][h]) begin
                found             = 1'b1;
                model_valid[w][h] = 1'b1;
                model_tag[w][h]   = k;
                id                = '{way: way_idx_t'(w), hash: h};
            end
        end
        full = !found;
    endtask

    task automatic model_unbind(input hash_idx_t h, input tag_t k);
        for (int w = 0; w < WAYS; w++) begin
            if (model_tag[w][h] == k) begin
                model_valid[w][h] = 1'b0;
            end
        end
    endtask

    // ----------------------------------------
    // Forward path
    // ----------------------------------------

    // One request per call, back to back when called in a row
    task automatic fw_send(input string name, input hash_idx_t h, input tag_t k);
        logic     hit;
        conn_id_t id;
        model_lookup(h, k, hit, id);
        @(posedge s00_axis_fw_lookup_aclk);
        #1;
        fw_req_valid = 1'b1;
        fw_req_ip    = k.ip;
        fw_req_port  = k.port;
        exp_name.push_back(name);
        exp_hit.push_back(hit);
        exp_id.push_back(id);
    endtask

    task automatic fw_drain();
        @(posedge s00_axis_fw_lookup_aclk);
        #1;
        fw_req_valid = 1'b0;
        while (exp_hit.size() != 0) @(negedge s00_axis_fw_lookup_aclk);
    endtask

    // Responses compared mid-cycle
    always @(negedge s00_axis_fw_lookup_aclk) begin
        if (rst_n && fw_resp_valid) begin
            if (exp_hit.size() == 0) begin
                errors++;
                $display("Forward response arrived with no lookup outstanding");
            end else begin
                mon_name = exp_name.pop_front();
                mon_hit  = exp_hit.pop_front();
                mon_id   = exp_id.pop_front();
                assert (fw_resp_hit == mon_hit && fw_resp_conn_id == mon_id) else begin
                    errors++;
                    $display("Error %s lookup: expected hit %0b id %h, actual hit %0b id %h",
                             mon_name, mon_hit, mon_id, fw_resp_hit, fw_resp_conn_id);
                end
            end
        end
    end

    // ----------------------------------------
    // Control path
    // ----------------------------------------

    // Returns just after the accepting edge, valid still high
    task automatic ctrl_issue(input tag_t k, input logic bind_op);
        @(posedge s00_axis_fw_lookup_aclk);
        #1;
        ctrl_req_valid = 1'b1;
        ctrl_req_ip    = k.ip;
        ctrl_req_port  = k.port;
        ctrl_req_bind  = bind_op;
        @(negedge s00_axis_fw_lookup_aclk);
        while (!ctrl_req_ready) @(negedge s00_axis_fw_lookup_aclk);
        @(posedge s00_axis_fw_lookup_aclk);
        #1;
    endtask

    task automatic ctrl_check(input string name, input logic full, input conn_id_t id);
        @(negedge s00_axis_fw_lookup_aclk);
        while (!ctrl_resp_valid) @(negedge s00_axis_fw_lookup_aclk);
        assert (ctrl_resp_full == full && ctrl_resp_conn_id == id) else begin
            errors++;
            $display("Error %s command: expected full %0b id %h, actual full %0b id %h",
                     name, full, id, ctrl_resp_full, ctrl_resp_conn_id);
        end
    endtask

    task automatic bind_key(input string name, input hash_idx_t h, input tag_t k);
        logic     full;
        conn_id_t id;
        model_bind(h, k, full, id);
        ctrl_issue(k, 1'b1);
        ctrl_req_valid = 1'b0;
        ctrl_check(name, full, id);
    endtask

    task automatic unbind_key(input string name, input hash_idx_t h, input tag_t k);
        model_unbind(h, k);
        ctrl_issue(k, 1'b0);
        ctrl_req_valid = 1'b0;
        ctrl_check(name, 1'b0, '0);
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------

    initial begin
        tag_t        k;
        logic        full;
        conn_id_t    id;
        logic [31:0] r;
        fw_req_valid   = 1'b0;
        fw_req_ip      = '0;
        fw_req_port    = '0;
        ctrl_req_valid = 1'b0;
        ctrl_req_ip    = '0;
        ctrl_req_port  = '0;
        ctrl_req_bind  = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            for (int i = 0; i < INDEXES; i++) begin
                model_valid[w][i] = 1'b0;
                model_tag[w][i]   = '0;
            end
        end
        r  = $random(seed);
        ha = r[3:0];
        hb = ha ^ 4'h1;
        for (int i = 0; i < 5; i++) make_key(ha, keys[i]);
        for (int i = 5; i < 7; i++) make_key(hb, keys[i]);
        @(posedge rst_n);

        // Empty table, requests every cycle
        for (int i = 0; i < 8; i++) begin
            make_key(hash_idx_t'(i * 5), k);
            fw_send("reset_miss", hash_idx_t'(i * 5), k);
        end
        fw_drain();

        bind_key("bind_new", ha, keys[0]);
        fw_send("bind_new", ha, keys[0]);
        fw_drain();

        // Same key again, then a colliding key takes the next way
        bind_key("bind_repeat", ha, keys[0]);
        bind_key("bind_repeat", ha, keys[1]);
        fw_send("bind_repeat", ha, keys[0]);
        fw_send("bind_repeat", ha, keys[1]);
        fw_drain();

        // Fifth colliding key finds the set full
        for (int i = 2; i < 5; i++) bind_key("set_full", ha, keys[i]);
        for (int i = 0; i < 5; i++) fw_send("set_full", ha, keys[i]);
        fw_drain();

        unbind_key("unbind", ha, keys[1]);
        fw_send("unbind", ha, keys[1]);
        fw_drain();
        bind_key("unbind", ha, keys[4]);
        for (int i = 0; i < 5; i++) fw_send("unbind", ha, keys[i]);
        fw_drain();

        // Second command held valid while the first is in flight
        model_bind(hb, keys[5], full, id);
        ctrl_issue(keys[5], 1'b1);
        ctrl_req_ip   = keys[6].ip;
        ctrl_req_port = keys[6].port;
        ctrl_check("ctrl_protocol", full, id);
        model_bind(hb, keys[6], full, id);
        ctrl_issue(keys[6], 1'b1);
        ctrl_req_valid = 1'b0;
        ctrl_check("ctrl_protocol", full, id);
        fw_send("ctrl_protocol", hb, keys[5]);
        fw_send("ctrl_protocol", hb, keys[6]);
        fw_drain();

        repeat (4) @(posedge s00_axis_fw_lookup_aclk);
        $display("Summary: %0d value errors, %0d assertion failures",
                 errors, i_dut.i_sva.fail_count);
        if (errors == 0 && i_dut.i_sva.fail_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Run length bound
    initial begin
        #(WATCHDOG_LIMIT);
        $display("Watchdog timeout: the tests did not finish within %0d time units",
                 WATCHDOG_LIMIT);
        $display("Summary: %0d value errors, %0d assertion failures",
                 errors, i_dut.i_sva.fail_count);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: vlog.f
hw/conn_pkg.sv
hw/conn_table_if.sv
hw/way_ram.sv
hw/conn_table.sv
hw/fw_lookup.sv
hw/bind_fsm.sv
hw/conn_manager.sv
tests/tb_clock.sv
tests/conn_manager_sva.sv
tests/tb_conn_manager.sv
